// ==== source/eth_rx_pkg.sv ====
package eth_rx_pkg;

   // station address
   // byte 0 on the wire is the top byte
   localparam logic [47:0] eth_mac_addr = 48'h02_5a_11_c4_7e_30;

   // start-of-frame delimiter, follows the 55h preamble
   localparam logic [7:0] eth_sfd = 8'hd5;

   // crc register left behind by a frame whose fcs is intact
   localparam logic [31:0] eth_crc_residue = 32'hc704_dd7b;

   // destination, source and type/length
   localparam int eth_hdr_len = 14;

   localparam int eth_fcs_len = 4;

   // frame buffer geometry
   localparam int eth_addr_w = 11;
   localparam int eth_buf_depth = 2 ** eth_addr_w;

endpackage

// ==== source/eth_crc.sv ====
module eth_crc (
   input  logic        RX_CLK,
   input  logic        rst,
   input  logic        start,
   input  logic [7:0]  data_in,
   input  logic        data_en,
   output logic [31:0] crc_value
);

   logic [31:0] crc_q;

   // one byte through the ethernet crc-32
   // data bits enter lsb first, register kept msb-aligned, so the
   // result is the bit-reversed image of the reflected shifter
   function automatic logic [31:0] crc_byte(
      input logic [31:0] crc,
      input logic [7:0]  data
   );
      logic [31:0] c;
      logic        fb;
      c = crc;
      for (int i = 0; i < 8; i++) begin
         fb = c[31] ^ data[i];
         c = {c[30:0], 1'b0} ^ (fb ? 32'h04c1_1db7 : 32'h0000_0000);
      end
      return c;
   endfunction

   always_ff @(posedge RX_CLK or posedge rst) begin
      if (rst) begin
         crc_q <= '1;
      end else if (start) begin
         crc_q <= '1;
      end else if (data_en) begin
         crc_q <= crc_byte(crc_q, data_in);
      end
   end

   // no final inversion, the receiver compares against the residue
   assign crc_value = crc_q;

endmodule

// ==== source/eth_rx_frame.sv ====
module eth_rx_frame
   import eth_rx_pkg::*;
(
   input  logic                  RX_CLK,
   input  logic                  rx_rst,
   input  logic                  rx_dv,
   input  logic [3:0]            rx_data,
   input  logic [eth_addr_w-1:0] nbytes,
   input  logic                  receive,
   output logic                  ready,
   output logic [eth_addr_w-1:0] wr_addr,
   output logic [7:0]            wr_data,
   output logic                  wr
);

   typedef enum logic [2:0] {
      st_hunt,
      st_lo,
      st_hi,
      st_pay_lo,
      st_pay_hi,
      st_done,
      st_held
   } state_t;

   state_t                state;

   logic [1:0]            rst_sync;
   logic                  rst_int;

   logic                  dv_q;
   logic [7:0]            sh_byte;
   logic [47:0]           dest_mac;

   logic [eth_addr_w-1:0] last_addr;
   logic                  mac_ok;
   logic [31:0]           crc_value;
   logic                  crc_ok;

   // reset sync, asserts at once, releases after two edges
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], 1'b0};
      end
   end

   assign rst_int = rst_sync[1];

   // mii capture
   always_ff @(posedge RX_CLK or posedge rst_int) begin
      if (rst_int) begin
         dv_q <= 1'b0;
      end else begin
         dv_q <= rx_dv;
      end
   end

   // newest nibble in the upper half
   always_ff @(posedge RX_CLK) begin
      sh_byte <= {rx_data, sh_byte[7:4]};
   end

   // address of the final fcs byte
   assign last_addr = nbytes + eth_addr_w'(eth_hdr_len + eth_fcs_len - 1);

   assign mac_ok = (dest_mac == eth_mac_addr);
   assign crc_ok = (crc_value == eth_crc_residue);

   // byte latch and destination address collection
   always_ff @(posedge RX_CLK) begin
      if (state == st_hi || state == st_pay_hi) begin
         wr_data <= sh_byte;
      end
      // bytes 0 to 5 are the destination
      if (state == st_hi && wr_addr < 6) begin
         dest_mac <= {dest_mac[39:0], sh_byte};
      end
   end

   // frame state machine
   always_ff @(posedge RX_CLK or posedge rst_int) begin
      if (rst_int) begin
         state   <= st_hunt;
         wr_addr <= '0;
         wr      <= 1'b0;
         ready   <= 1'b0;
      end else begin
         wr <= 1'b0;
         if (wr) begin
            wr_addr <= wr_addr + 1'b1;
         end

         case (state)
            st_hunt: begin
               wr_addr <= '0;
               if (dv_q && sh_byte == eth_sfd) begin
                  state <= st_lo;
               end
            end

            st_lo: begin
               state <= dv_q ? st_hi : st_hunt;
            end

            // header byte complete, check destination at byte 6
            st_hi: begin
               if (!dv_q) begin
                  state <= st_hunt;
               end else if (wr_addr == 6 && !mac_ok) begin
                  state <= st_hunt;
               end else begin
                  wr    <= 1'b1;
                  state <= (wr_addr == 6) ? st_pay_lo : st_lo;
               end
            end

            st_pay_lo: begin
               if (wr_addr == last_addr) begin
                  // last byte goes out now, anything more is overlong
                  state <= dv_q ? st_hunt : st_done;
               end else begin
                  state <= dv_q ? st_pay_hi : st_hunt;
               end
            end

            st_pay_hi: begin
               if (dv_q) begin
                  wr    <= 1'b1;
                  state <= st_pay_lo;
               end else begin
                  state <= st_hunt;
               end
            end

            // crc has taken the last fcs byte
            st_done: begin
               if (crc_ok) begin
                  ready <= 1'b1;
                  state <= st_held;
               end else begin
                  state <= st_hunt;
               end
            end

            // buffer owned by the host until receive
            st_held: begin
               if (receive) begin
                  ready <= 1'b0;
                  state <= st_hunt;
               end
            end

            default: begin
               state <= st_hunt;
            end
         endcase
      end
   end

   eth_crc crc_rx (
      .RX_CLK    (RX_CLK),
      .rst       (rst_int),
      .start     (state == st_hunt),
      .data_in   (wr_data),
      .data_en   (wr),
      .crc_value (crc_value)
   );

endmodule

// ==== source/eth_rx_buffer.sv ====
module eth_rx_buffer
   import eth_rx_pkg::*;
(
   input  logic                  RX_CLK,

   // write side, from the frame receiver
   input  logic                  wr,
   input  logic [eth_addr_w-1:0] wr_addr,
   input  logic [7:0]            wr_data,

   // read side, host
   input  logic [eth_addr_w-1:0] rd_addr,
   output logic [7:0]            rd_data
);

   logic [7:0] mem [eth_buf_depth];

   always_ff @(posedge RX_CLK) begin
      if (wr) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read for block ram
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== source/eth_rx.sv ====
module eth_rx
   import eth_rx_pkg::*;
(
   input  logic                  RX_CLK,
   input  logic                  rx_rst,

   // mii receive
   input  logic                  rx_dv,
   input  logic [3:0]            rx_data,

   // host
   input  logic [eth_addr_w-1:0] nbytes,
   input  logic                  receive,
   output logic                  ready,
   input  logic [eth_addr_w-1:0] rd_addr,
   output logic [7:0]            rd_data
);

   logic                  wr;
   logic [eth_addr_w-1:0] wr_addr;
   logic [7:0]            wr_data;

   eth_rx_frame rx_frame (
      .RX_CLK  (RX_CLK),
      .rx_rst  (rx_rst),
      .rx_dv   (rx_dv),
      .rx_data (rx_data),
      .nbytes  (nbytes),
      .receive (receive),
      .ready   (ready),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .wr      (wr)
   );

   // frame store, read directly by the host
   eth_rx_buffer rx_buffer (
      .RX_CLK  (RX_CLK),
      .wr      (wr),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// ==== bench/eth_frame_model.svh ====
logic [31:0] lcg_state = 32'h01b8_62e2;

// frame under construction, without preamble and sfd
logic [7:0]  tx_frame[$];

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// roughly uniform value in lo..hi from the upper lcg bits
function automatic int rand_range(input int lo, input int hi);
   logic [31:0] r;
   int unsigned span;
   r = lcg_next();
   span = hi - lo + 1;
   return lo + int'((r >> 8) % span);
endfunction

// ethernet crc-32 over the first len bytes of tx_frame
// reflected form with the final inversion applied
// the low byte goes on the wire first
function automatic logic [31:0] fcs_of(input int len);
   logic [31:0] c;
   logic [7:0]  b;
   c = 32'hffff_ffff;
   for (int k = 0; k < len; k++) begin
      b = tx_frame[k];
      c = c ^ {24'h00_0000, b};
      for (int j = 0; j < 8; j++) begin
         c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
      end
   end
   return ~c;
endfunction

// destination, source, type, n payload bytes, fcs
function automatic void build_frame(input logic [47:0] dest, input int n);
   logic [47:0] src;
   logic [31:0] r;
   logic [31:0] fcs;
   src = 48'h06_3c_a1_5e_90_24;
   tx_frame.delete();
   for (int i = 0; i < 6; i++) begin
      tx_frame.push_back(dest[47 - 8 * i -: 8]);
   end
   for (int i = 0; i < 6; i++) begin
      tx_frame.push_back(src[47 - 8 * i -: 8]);
   end
   // local experimental ethertype
   tx_frame.push_back(8'h88);
   tx_frame.push_back(8'hb5);
   for (int i = 0; i < n; i++) begin
      r = lcg_next();
      tx_frame.push_back(r[23:16]);
   end
   fcs = fcs_of(tx_frame.size());
   tx_frame.push_back(fcs[7:0]);
   tx_frame.push_back(fcs[15:8]);
   tx_frame.push_back(fcs[23:16]);
   tx_frame.push_back(fcs[31:24]);
endfunction

// ==== bench/tb_eth_rx.sv ====
module tb_eth_rx
   import eth_rx_pkg::*;
();

   logic                  RX_CLK;
   logic                  rx_rst;
   logic                  rx_dv;
   logic [3:0]            rx_data;
   logic [eth_addr_w-1:0] nbytes;
   logic                  receive;
   logic                  ready;
   logic [eth_addr_w-1:0] rd_addr;
   logic [7:0]            rd_data;

   // frame the buffer should hold
   logic [7:0]            exp_frame[$];
   logic                  rd_check;

   int                    cycle_count = 0;
   // reset, idle check and some slack
   int                    cycle_budget = 8 + 10 + 64;

   `include "eth_frame_model.svh"

   eth_rx uut (
      .RX_CLK  (RX_CLK),
      .rx_rst  (rx_rst),
      .rx_dv   (rx_dv),
      .rx_data (rx_data),
      .nbytes  (nbytes),
      .receive (receive),
      .ready   (ready),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #10 RX_CLK = ~RX_CLK;
   end

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1);
   endtask

   // budget grows as frames are queued
   always @(posedge RX_CLK) begin
      cycle_count++;
      assert (cycle_count <= cycle_budget)
      else report_failure($sformatf("timeout after %0d cycles, test did not finish",
                                    cycle_count));
   end

   // rd_data is valid here for the address sampled on this edge
   always @(posedge RX_CLK) begin
      #1;
      if (rd_check) begin
         assert (rd_data === exp_frame[rd_addr])
         else report_failure($sformatf("** Error: rd_data at %h got %h expected %h",
                                       rd_addr, rd_data, exp_frame[rd_addr]));
      end
   end

   task automatic send_nibble(input logic [3:0] n);
      rx_dv = 1'b1;
      rx_data = n;
      @(posedge RX_CLK);
      #2;
   endtask

   // low nibble first
   task automatic send_byte(input logic [7:0] b);
      send_nibble(b[3:0]);
      send_nibble(b[7:4]);
   endtask

   task automatic send_frame(input int pre_len);
      cycle_budget += 2 * (pre_len + 1 + tx_frame.size()) + 64;
      for (int i = 0; i < pre_len; i++) begin
         send_byte(8'h55);
      end
      send_byte(eth_sfd);
      foreach (tx_frame[i]) begin
         send_byte(tx_frame[i]);
      end
      rx_dv = 1'b0;
      rx_data = 4'h0;
   endtask

   task automatic await_ready();
      int waited;
      waited = 0;
      while (!ready && waited < 4) begin
         @(posedge RX_CLK);
         #2;
         waited++;
      end
      assert (ready === 1'b1)
      else report_failure("ready did not rise within 4 cycles of the end of the frame");
   endtask

   // ready must keep one level for a number of cycles
   task automatic hold_check(input logic level, input int cycles, input string what);
      for (int i = 0; i < cycles; i++) begin
         @(posedge RX_CLK);
         #2;
         assert (ready === level)
         else report_failure(what);
      end
   endtask

   task automatic read_frame();
      cycle_budget += exp_frame.size() + 4;
      for (int a = 0; a < exp_frame.size(); a++) begin
         rd_addr = eth_addr_w'(a);
         rd_check = 1'b1;
         @(posedge RX_CLK);
         #2;
      end
      rd_check = 1'b0;
   endtask

   task automatic release_buffer();
      receive = 1'b1;
      @(posedge RX_CLK);
      #2;
      receive = 1'b0;
      @(posedge RX_CLK);
      #2;
      assert (ready === 1'b0)
      else report_failure("ready stayed high after receive");
   endtask

   task automatic good_frame();
      int n;
      n = rand_range(46, 200);
      build_frame(eth_mac_addr, n);
      nbytes = eth_addr_w'(n);
      send_frame(rand_range(3, 7));
      await_ready();
      exp_frame = tx_frame;
      read_frame();
      release_buffer();
   endtask

   initial begin
      int n;
      int idx;
      rx_rst = 1'b1;
      rx_dv = 1'b0;
      rx_data = 4'h0;
      nbytes = '0;
      receive = 1'b0;
      rd_addr = '0;
      rd_check = 1'b0;
      repeat (8) @(posedge RX_CLK);
      #2;
      rx_rst = 1'b0;

      hold_check(1'b0, 10, "ready rose while the line was idle after reset");

      for (int f = 0; f < 4; f++) begin
         good_frame();
      end

      // one bit off in the destination
      n = rand_range(46, 200);
      build_frame(eth_mac_addr ^ 48'h0000_0000_0100, n);
      nbytes = eth_addr_w'(n);
      send_frame(rand_range(3, 7));
      hold_check(1'b0, 12, "ready rose for a frame addressed to another station");
      good_frame();

      // payload damaged after the fcs was computed
      n = rand_range(46, 200);
      build_frame(eth_mac_addr, n);
      idx = eth_hdr_len + rand_range(0, n - 1);
      tx_frame[idx] = tx_frame[idx] ^ 8'h24;
      nbytes = eth_addr_w'(n);
      send_frame(rand_range(3, 7));
      hold_check(1'b0, 12, "ready rose for a frame with a bad fcs");
      good_frame();

      // second frame arrives while the first is still held
      n = rand_range(46, 200);
      build_frame(eth_mac_addr, n);
      nbytes = eth_addr_w'(n);
      send_frame(rand_range(3, 7));
      await_ready();
      exp_frame = tx_frame;
      n = rand_range(46, 200);
      build_frame(eth_mac_addr, n);
      nbytes = eth_addr_w'(n);
      send_frame(rand_range(3, 7));
      hold_check(1'b1, 12, "ready dropped while a frame was held");
      read_frame();
      release_buffer();
      good_frame();

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+bench
source/eth_rx_pkg.sv
source/eth_crc.sv
source/eth_rx_frame.sv
source/eth_rx_buffer.sv
source/eth_rx.sv
bench/tb_eth_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the receive testbench with verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project root"
   exit 1
fi

command -v verilator > /dev/null
if [ $? -ne 0 ]; then
   echo "verilator not found"
   exit 1
fi

verilator --binary --timing --assert --top-module tb_eth_rx -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vtb_eth_rx 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "simulator exited with status $sim_status"
   exit 1
fi

printf '%s\n' "$sim_out" | grep -qx "Simulation completed successfully"
if [ $? -ne 0 ]; then
   echo "pass message not found"
   exit 1
fi

exit 0
